//--- Bender.yml
package:
  name: tia_video

sources:
  - rtl/tia_pkg.sv
  - rtl/tia_beam_if.sv
  - rtl/tia_pf_if.sv
  - rtl/tia_regs.sv
  - rtl/tia_beam.sv
  - rtl/tia_render.sv
  - rtl/tia_top.sv
  - target: test
    files:
      - verif/tia_checker.sv
      - verif/tia_tb.sv

//--- rtl/tia_beam.sv
// Beam counter
// Horizontal and vertical position, frame restart on VSYNC
// and the WSYNC CPU stall flag
`timescale 1ns/100ps
`default_nettype none

module tia_beam #(
  parameter int FRAME_LINES = 262
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      enable_i,
  output logic     stall_cpu_o,
  tia_beam_if.beam beam
);
  import tia_pkg::*;

  logic line_end;
  logic frame_end;

  assign line_end  = beam.xpos == xpos_t'(LINE_CLOCKS - 1);
  assign frame_end = beam.ypos >= ypos_t'(FRAME_LINES - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      beam.xpos <= '0;
      beam.ypos <= '0;
    end else if (beam.restart_p) begin
      beam.xpos <= '0;                  // Rising VSYNC restarts the frame
      beam.ypos <= '0;
    end else if (enable_i) begin
      if (frame_end) begin
        beam.ypos <= '0;
      end else if (line_end) begin
        beam.xpos <= '0;
        beam.ypos <= ypos_t'(beam.ypos + 1'b1);
      end else begin
        beam.xpos <= xpos_t'(beam.xpos + 1'b1);
      end
    end
  end

  // CPU is held until the beam leaves the visible part of the line
  always_ff @(posedge clk) begin
    if (reset) begin
      stall_cpu_o <= 1'b0;
    end else if (beam.wsync_p) begin
      stall_cpu_o <= 1'b1;
    end else if (beam.xpos == xpos_t'(VISIBLE_W)) begin
      stall_cpu_o <= 1'b0;              // Independent of enable_i
    end
  end

  xpos_in_line: assert property (
    @(posedge clk) disable iff (reset)
    beam.xpos <= xpos_t'(LINE_CLOCKS - 1)
  );

endmodule

`default_nettype wire

//--- rtl/tia_beam_if.sv
// Beam position and beam-control pulses
// shared by the register file, beam counter and renderer
`timescale 1ns/100ps
`default_nettype none

interface tia_beam_if;
  import tia_pkg::*;

  xpos_t xpos;        // Horizontal beam position
  ypos_t ypos;        // Current line
  logic  wsync_p;     // WSYNC write seen
  logic  restart_p;   // VSYNC rising, restart frame

  modport beam (
    output xpos,
    output ypos,
    input  wsync_p,
    input  restart_p
  );

  modport regs (
    input  xpos,
    output wsync_p,
    output restart_p
  );

  modport view (
    input xpos,
    input ypos
  );

endinterface

`default_nettype wire

//--- rtl/tia_pf_if.sv
// Playfield, ball, colour and collision state
// passed from the register file to the renderer
`timescale 1ns/100ps
`default_nettype none

interface tia_pf_if;
  import tia_pkg::*;

  color_t colubk;
  color_t colupf;
  color_t colup0;        // Score colour, left half
  color_t colup1;        // Score colour, right half
  pf_t    pf;
  logic   refpf;         // Mirror the right half
  logic   scorepf;
  logic   pf_priority;
  logic   enabl;
  xpos_t  x_bl;          // Ball start column
  bsize_t ball_w;
  logic   cxclr_p;       // Collision clear pulse
  logic   cx_blpf;       // Ball/playfield collision latch

  modport regs (
    output colubk, colupf, colup0, colup1,
    output pf, refpf, scorepf, pf_priority,
    output enabl, x_bl, ball_w, cxclr_p,
    input  cx_blpf
  );

  modport render (
    input  colubk, colupf, colup0, colup1,
    input  pf, refpf, scorepf, pf_priority,
    input  enabl, x_bl, ball_w, cxclr_p,
    output cx_blpf
  );

endinterface

`default_nettype wire

//--- rtl/tia_pkg.sv
// Shared definitions for the TIA video core
// Bus widths, pixel and position types, the register map
// and the horizontal line geometry
`default_nettype none

package tia_pkg;

  localparam int DATA_W = 8;   // CPU data bus
  localparam int ADDR_W = 6;   // Register address

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [6:0]  color_t;   // Bits 7..1 of the written byte
  typedef logic [7:0]  xpos_t;    // 0 to LINE_CLOCKS-1
  typedef logic [8:0]  ypos_t;    // Line number within the frame
  typedef logic [19:0] pf_t;      // Drawing order of the left half
  typedef logic [15:0] vaddr_t;   // Frame-buffer address
  typedef logic [3:0]  bsize_t;   // Ball width, 1 to 8 clocks

  // Horizontal geometry, identical for NTSC and PAL
  localparam int LINE_CLOCKS = 228;
  localparam int VISIBLE_W   = 160;
  localparam int RES_DELAY   = 5;   // RESBL lands a few clocks late

  // Write addresses that the core decodes
  typedef enum addr_t {
    VSYNC  = 6'h00,
    VBLANK = 6'h01,
    WSYNC  = 6'h02,
    COLUP0 = 6'h06,
    COLUP1 = 6'h07,
    COLUPF = 6'h08,
    COLUBK = 6'h09,
    CTRLPF = 6'h0a,
    PF0    = 6'h0d,
    PF1    = 6'h0e,
    PF2    = 6'h0f,
    RESBL  = 6'h14,
    ENABL  = 6'h1f,
    CXCLR  = 6'h2c
  } reg_addr_e;

  // Only readable address left
  localparam addr_t CXBLPF = 6'h06;

endpackage

`default_nettype wire

//--- rtl/tia_regs.sv
// TIA register file
// Write decode and storage, the CXBLPF read port,
// and the restart, WSYNC and collision-clear pulses
`timescale 1ns/100ps
`default_nettype none

module tia_regs (
  input  wire            clk,
  input  wire            reset,
  input  wire            cpu_enable_i,
  input  wire            stb_i,
  input  wire            we_i,
  input  tia_pkg::addr_t adr_i,
  input  tia_pkg::data_t dat_i,
  output tia_pkg::data_t dat_o,
  output logic           vsync_o,
  output logic           vblank_o,
  tia_beam_if.regs       beam,
  tia_pf_if.regs         pf
);
  import tia_pkg::*;

  logic wr_en;
  logic rd_en;
  logic vsync_q;
  logic vblank_q;

  assign wr_en = stb_i && we_i && cpu_enable_i;   // Write lands on this edge
  assign rd_en = stb_i && !we_i;

  // Pulses act on the same edge as the write itself
  assign beam.restart_p = wr_en && (adr_i == VSYNC) && !vsync_q && dat_i[1];
  assign beam.wsync_p   = wr_en && (adr_i == WSYNC);
  assign pf.cxclr_p     = wr_en && (adr_i == CXCLR);

  assign vsync_o  = vsync_q;
  assign vblank_o = vblank_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      vsync_q        <= 1'b0;
      vblank_q       <= 1'b0;
      pf.colubk      <= '0;
      pf.colupf      <= '0;
      pf.colup0      <= '0;
      pf.colup1      <= '0;
      pf.pf          <= '0;
      pf.refpf       <= 1'b0;
      pf.scorepf     <= 1'b0;
      pf.pf_priority <= 1'b0;
      pf.enabl       <= 1'b0;
      pf.x_bl        <= '0;
      pf.ball_w      <= bsize_t'(1);   // Same as CTRLPF = 0
    end else if (wr_en) begin
      case (adr_i)
        VSYNC:  vsync_q   <= dat_i[1];
        VBLANK: vblank_q  <= dat_i[1];
        COLUP0: pf.colup0 <= dat_i[7:1];
        COLUP1: pf.colup1 <= dat_i[7:1];
        COLUPF: pf.colupf <= dat_i[7:1];
        COLUBK: pf.colubk <= dat_i[7:1];
        CTRLPF: begin
          pf.ball_w      <= bsize_t'(1) << dat_i[5:4];
          pf.refpf       <= dat_i[0];
          pf.scorepf     <= dat_i[1];
          pf.pf_priority <= dat_i[2];
        end
        PF0: begin
          for (int i = 0; i < 4; i++) begin
            pf.pf[i] <= dat_i[4+i];      // Upper nibble only
          end
        end
        PF1: begin
          for (int i = 0; i < 8; i++) begin
            pf.pf[4+i] <= dat_i[7-i];    // MSB drawn first
          end
        end
        PF2: begin
          for (int i = 0; i < 8; i++) begin
            pf.pf[12+i] <= dat_i[i];
          end
        end
        RESBL: begin
          if (beam.xpos >= xpos_t'(VISIBLE_W)) begin
            pf.x_bl <= '0;               // Reset during HBLANK
          end else begin
            pf.x_bl <= xpos_t'(beam.xpos + xpos_t'(RES_DELAY));
          end
        end
        ENABL:  pf.enabl <= dat_i[1];
        default: ;                       // WSYNC, CXCLR are pulses only
      endcase
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (adr_i == CXBLPF) begin
        dat_o <= {pf.cx_blpf, 7'b0};
      end else begin
        dat_o <= '0;
      end
    end
  end

  // A restart needs VSYNC low first, so it can never repeat back to back
  restart_single: assert property (
    @(posedge clk) disable iff (reset)
    beam.restart_p |=> !beam.restart_p
  );

endmodule

`default_nettype wire

//--- rtl/tia_render.sv
// Pixel logic
// Playfield and ball bits, colour priority,
// ball/playfield collision latch and the frame-buffer write port
`timescale 1ns/100ps
`default_nettype none

module tia_render #(
  parameter int FIRST_LINE         = 22,
  parameter int FIRST_PICTURE_LINE = 38
) (
  input  wire             clk,
  input  wire             reset,
  input  wire             enable_i,
  output tia_pkg::color_t vid_out_o,
  output logic            vid_wr_o,
  output tia_pkg::vaddr_t vid_addr_o,
  tia_beam_if.view        beam,
  tia_pf_if.render        pf
);
  import tia_pkg::*;

  localparam int HALF_W = VISIBLE_W / 2;

  logic       in_vis;
  logic       left_half;
  xpos_t      pf_pos;
  logic [4:0] pf_idx;
  logic       pf_bit;
  logic [8:0] bl_end;
  logic       bl_bit;
  color_t     pf_color;
  color_t     pixel;
  logic       draw;

  assign in_vis    = beam.xpos < xpos_t'(VISIBLE_W);
  assign left_half = beam.xpos < xpos_t'(HALF_W);

  // Column within the 80-clock half, mirrored when reflecting
  always_comb begin
    if (left_half) begin
      pf_pos = beam.xpos;
    end else if (pf.refpf) begin
      pf_pos = xpos_t'(VISIBLE_W - 1) - beam.xpos;
    end else begin
      pf_pos = beam.xpos - xpos_t'(HALF_W);
    end
  end

  assign pf_idx = pf_pos[6:2];                 // Four clocks per bit
  assign pf_bit = in_vis && pf.pf[pf_idx];

  assign bl_end = 9'(pf.x_bl) + 9'(pf.ball_w);
  assign bl_bit = pf.enabl && (beam.xpos >= pf.x_bl) && (9'(beam.xpos) < bl_end);

  // Score mode tints each half with the player colour
  assign pf_color = pf.scorepf ? (left_half ? pf.colup0 : pf.colup1) : pf.colupf;

  always_comb begin
    if (bl_bit) begin
      pixel = pf.colupf;
    end else if (pf_bit) begin
      pixel = pf_color;
    end else begin
      pixel = pf.colubk;
    end
  end

  assign draw = enable_i && in_vis && (beam.ypos >= ypos_t'(FIRST_LINE));

  assign vid_addr_o = vaddr_t'((vaddr_t'(beam.ypos) - vaddr_t'(FIRST_LINE))
                      * vaddr_t'(VISIBLE_W) + vaddr_t'(beam.xpos));

  always_ff @(posedge clk) begin
    if (reset) begin
      vid_wr_o <= 1'b0;
    end else begin
      vid_wr_o <= draw;                        // One-cycle write pulse
    end
  end

  always_ff @(posedge clk) begin
    if (draw) begin
      if (beam.ypos >= ypos_t'(FIRST_PICTURE_LINE)) begin
        vid_out_o <= pixel;
      end else begin
        vid_out_o <= '0;                       // Top lines stay black
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pf.cx_blpf <= 1'b0;
    end else if (pf.cxclr_p) begin
      pf.cx_blpf <= 1'b0;
    end else if (enable_i && bl_bit && pf_bit) begin
      pf.cx_blpf <= 1'b1;
    end
  end

  // Each write belongs to a visible column of the previous cycle
  wr_in_visible: assert property (
    @(posedge clk) disable iff (reset)
    $rose(vid_wr_o) |-> $past(beam.xpos) < xpos_t'(VISIBLE_W)
  );

endmodule

`default_nettype wire

//--- rtl/tia_top.sv
// TIA video core top level
// Plain bus and video ports, frame geometry parameters,
// register file, beam counter and renderer
`timescale 1ns/100ps
`default_nettype none

module tia_top #(
  parameter int FRAME_LINES        = 262,   // NTSC defaults
  parameter int FIRST_LINE         = 22,
  parameter int FIRST_PICTURE_LINE = 38
) (
  input  wire             clk,
  input  wire             reset,
  input  wire             enable_i,        // Pixel clock enable
  input  wire             cpu_enable_i,
  input  wire             stb_i,
  input  wire             we_i,
  input  tia_pkg::addr_t  adr_i,
  input  tia_pkg::data_t  dat_i,
  output tia_pkg::data_t  dat_o,
  output logic            stall_cpu_o,
  output tia_pkg::color_t vid_out_o,
  output logic            vid_wr_o,
  output tia_pkg::vaddr_t vid_addr_o,
  output tia_pkg::xpos_t  vid_xpos_o,
  output tia_pkg::ypos_t  vid_ypos_o,
  output logic            vid_vblank_o,
  output logic            vid_vsync_o
);

  tia_beam_if beam_if ();
  tia_pf_if   pf_if ();

  assign vid_xpos_o = beam_if.xpos;
  assign vid_ypos_o = beam_if.ypos;

  tia_regs i_regs (
    .clk          (clk),
    .reset        (reset),
    .cpu_enable_i (cpu_enable_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .vsync_o      (vid_vsync_o),
    .vblank_o     (vid_vblank_o),
    .beam         (beam_if.regs),
    .pf           (pf_if.regs)
  );

  tia_beam #(
    .FRAME_LINES (FRAME_LINES)
  ) i_beam (
    .clk         (clk),
    .reset       (reset),
    .enable_i    (enable_i),
    .stall_cpu_o (stall_cpu_o),
    .beam        (beam_if.beam)
  );

  tia_render #(
    .FIRST_LINE         (FIRST_LINE),
    .FIRST_PICTURE_LINE (FIRST_PICTURE_LINE)
  ) i_render (
    .clk        (clk),
    .reset      (reset),
    .enable_i   (enable_i),
    .vid_out_o  (vid_out_o),
    .vid_wr_o   (vid_wr_o),
    .vid_addr_o (vid_addr_o),
    .beam       (beam_if.view),
    .pf         (pf_if.render)
  );

endmodule

`default_nettype wire

//--- verif/tia_checker.sv
// Checker for the TIA video core
// Mirrors bus writes into a register model and predicts pixels,
// write strobes, frame-buffer addresses, sync outputs and CXBLPF reads
`timescale 1ns/100ps
`default_nettype none

module tia_checker #(
  parameter int FIRST_LINE         = 22,
  parameter int FIRST_PICTURE_LINE = 38
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        enable_i,
  input  wire        cpu_enable_i,
  input  wire        stb_i,
  input  wire        we_i,
  input  wire [5:0]  adr_i,
  input  wire [7:0]  dat_i,
  input  wire [7:0]  dat_rd_i,      // DUT read data
  input  wire [6:0]  vid_out_i,
  input  wire        vid_wr_i,
  input  wire [15:0] vid_addr_i,
  input  wire [7:0]  vid_xpos_i,
  input  wire [8:0]  vid_ypos_i,
  input  wire        vid_vblank_i,
  input  wire        vid_vsync_i,
  input  wire [95:0] test_name_i,
  output int         errors_o,
  output int         checks_o
);
  import tia_pkg::*;

  logic [6:0] colubk;
  logic [6:0] colupf;
  logic [6:0] colup0;
  logic [6:0] colup1;
  logic [7:0] pf0;
  logic [7:0] pf1;
  logic [7:0] pf2;
  logic       refpf;
  logic       scorepf;
  logic       enabl;
  logic       cx;              // Ball/playfield collision
  logic       vsync;
  logic       vblank;
  int         x_bl;
  int         ball_w;
  logic       wr_due;          // Pixel write expected at next edge
  logic       rd_due;
  logic [6:0] exp_pix;
  logic [7:0] exp_rd;

  // Playfield bit under column x, straight from the register bytes
  function automatic logic pf_at(input int x);
    int idx;
    if (x >= VISIBLE_W) return 1'b0;
    if (x < VISIBLE_W / 2) begin
      idx = x / 4;
    end else if (refpf) begin
      idx = (VISIBLE_W - 1 - x) / 4;
    end else begin
      idx = (x - VISIBLE_W / 2) / 4;
    end
    if (idx < 4) return pf0[4 + idx];    // PF0 upper nibble, bit 4 first
    if (idx < 12) return pf1[11 - idx];  // PF1 bit 7 first
    return pf2[idx - 12];
  endfunction

  function automatic logic ball_at(input int x);
    return enabl && (x >= x_bl) && (x < x_bl + ball_w);
  endfunction

  function automatic logic [6:0] color_at(input int x, input int y);
    if (y < FIRST_PICTURE_LINE) return 7'd0;
    if (ball_at(x)) return colupf;
    if (pf_at(x)) begin
      if (!scorepf) return colupf;
      return (x < VISIBLE_W / 2) ? colup0 : colup1;
    end
    return colubk;
  endfunction

  task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
    checks_o++;
    if (exp !== act) begin
      errors_o++;
      $display("Error [%0s] %0s expected %h actual %h", test_name_i, what, exp, act);
    end
  endtask

  task automatic apply_write(input int x);
    case (adr_i)
      VSYNC:  vsync  = dat_i[1];
      VBLANK: vblank = dat_i[1];
      COLUP0: colup0 = dat_i[7:1];
      COLUP1: colup1 = dat_i[7:1];
      COLUPF: colupf = dat_i[7:1];
      COLUBK: colubk = dat_i[7:1];
      CTRLPF: begin
        refpf   = dat_i[0];
        scorepf = dat_i[1];
        ball_w  = 1 << dat_i[5:4];
      end
      PF0:    pf0 = dat_i;
      PF1:    pf1 = dat_i;
      PF2:    pf2 = dat_i;
      RESBL:  x_bl = (x >= VISIBLE_W) ? 0 : x + RES_DELAY;
      ENABL:  enabl = dat_i[1];
      default: ;
    endcase
  endtask

  // Values before the edge, the same ones the DUT registers
  always @(posedge clk) begin : model_step
    int x;
    int y;
    x = vid_xpos_i;
    y = vid_ypos_i;
    if (reset) begin
      {colubk, colupf, colup0, colup1} = '0;
      {pf0, pf1, pf2} = '0;
      {refpf, scorepf, enabl, cx, vsync, vblank} = '0;
      x_bl   = 0;
      ball_w = 1;
      wr_due = 1'b0;
      rd_due = 1'b0;
    end else begin
      compare("vid_wr", wr_due, vid_wr_i);
      if (wr_due) compare("pixel", exp_pix, vid_out_i);
      if (rd_due) compare("read", exp_rd, dat_rd_i);
      if (x < VISIBLE_W && y >= FIRST_LINE) begin
        compare("vid_addr", 16'((y - FIRST_LINE) * VISIBLE_W + x), vid_addr_i);
      end
      compare("vsync", vsync, vid_vsync_i);
      compare("vblank", vblank, vid_vblank_i);
      wr_due  = enable_i && (x < VISIBLE_W) && (y >= FIRST_LINE);
      exp_pix = color_at(x, y);
      rd_due  = stb_i && !we_i;
      exp_rd  = (adr_i == CXBLPF) ? {cx, 7'b0} : 8'h00;
      if (stb_i && we_i && cpu_enable_i && adr_i == CXCLR) begin
        cx = 1'b0;
      end else if (enable_i && ball_at(x) && pf_at(x)) begin
        cx = 1'b1;
      end
      if (stb_i && we_i && cpu_enable_i) apply_write(x);
    end
  end

endmodule

`default_nettype wire

//--- verif/tia_tb.sv
// Testbench for the TIA video core
// Clock and reset, a table of register writes applied in a loop,
// collision, WSYNC and VSYNC sequences and the closing summary
`timescale 1ns/100ps
`default_nettype none

module tia_tb;
  import tia_pkg::*;

  localparam int FRAME_LINES        = 262;
  localparam int FIRST_LINE         = 22;
  localparam int FIRST_PICTURE_LINE = 38;
  localparam int BUS_TIMEOUT        = 8;
  localparam int LINE_TIMEOUT       = 2 * LINE_CLOCKS;

  typedef struct packed {
    logic [95:0] name;
    addr_t       addr;
    data_t       data;
    logic [7:0]  lines;          // Lines to run after the write
  } step_t;

  logic        clk;
  logic        reset;
  logic        enable;
  logic        cpu_enable;
  logic        stb;
  logic        we;
  addr_t       adr;
  data_t       dat;
  wire [7:0]   dat_rd;
  wire         stall_cpu;
  wire [6:0]   vid_out;
  wire         vid_wr;
  wire [15:0]  vid_addr;
  wire [7:0]   vid_xpos;
  wire [8:0]   vid_ypos;
  wire         vid_vblank;
  wire         vid_vsync;
  int          chk_errors;
  int          chk_checks;
  logic [95:0] cur_name;
  step_t       steps[$];
  int          seed;
  int          tb_errors;
  int          tb_checks;
  data_t       rd_val;
  int          last_x;
  int          waited;

  tia_top #(
    .FRAME_LINES        (FRAME_LINES),
    .FIRST_LINE         (FIRST_LINE),
    .FIRST_PICTURE_LINE (FIRST_PICTURE_LINE)
  ) i_dut (
    .clk (clk), .reset (reset), .enable_i (enable), .cpu_enable_i (cpu_enable),
    .stb_i (stb), .we_i (we), .adr_i (adr), .dat_i (dat), .dat_o (dat_rd),
    .stall_cpu_o (stall_cpu), .vid_out_o (vid_out), .vid_wr_o (vid_wr),
    .vid_addr_o (vid_addr), .vid_xpos_o (vid_xpos), .vid_ypos_o (vid_ypos),
    .vid_vblank_o (vid_vblank), .vid_vsync_o (vid_vsync)
  );

  tia_checker #(
    .FIRST_LINE         (FIRST_LINE),
    .FIRST_PICTURE_LINE (FIRST_PICTURE_LINE)
  ) i_chk (
    .clk (clk), .reset (reset), .enable_i (enable), .cpu_enable_i (cpu_enable),
    .stb_i (stb), .we_i (we), .adr_i (adr), .dat_i (dat), .dat_rd_i (dat_rd),
    .vid_out_i (vid_out), .vid_wr_i (vid_wr), .vid_addr_i (vid_addr),
    .vid_xpos_i (vid_xpos), .vid_ypos_i (vid_ypos), .vid_vblank_i (vid_vblank),
    .vid_vsync_i (vid_vsync), .test_name_i (cur_name),
    .errors_o (chk_errors), .checks_o (chk_checks)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // CPU bus slot one cycle in three
  initial begin : cpu_slots
    int phase;
    phase      = 0;
    cpu_enable = 1'b0;
    forever begin
      @(negedge clk);
      phase      = (phase + 1) % 3;
      cpu_enable = (phase == 0);
    end
  end

  function automatic data_t rand_byte();
    return data_t'($random(seed));
  endfunction

  task automatic note_timeout(input string what);
    tb_errors++;
    $display("Timeout: %0s did not happen in time", what);
  endtask

  task automatic check_value(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    tb_checks++;
    if (exp !== act) begin
      tb_errors++;
      $display("Error [%0s] %0s expected %h actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic add_step(input logic [95:0] name, input addr_t addr,
                          input data_t data, input logic [7:0] lines);
    step_t s;
    s.name  = name;
    s.addr  = addr;
    s.data  = data;
    s.lines = lines;
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step("background", COLUBK, rand_byte(), 8'd0);
    add_step("pf_color",   COLUPF, rand_byte(), 8'd0);
    add_step("score_p0",   COLUP0, rand_byte(), 8'd0);
    add_step("score_p1",   COLUP1, rand_byte(), 8'd42);   // Crosses the picture start
    add_step("pf0",        PF0,    8'ha0,       8'd2);
    add_step("pf1",        PF1,    8'h96,       8'd2);
    add_step("pf2",        PF2,    8'h3c,       8'd2);
    add_step("reflect",    CTRLPF, 8'h01,       8'd2);
    add_step("score",      CTRLPF, 8'h02,       8'd2);
    add_step("score_refl", CTRLPF, 8'h03,       8'd2);
    add_step("ball_on",    ENABL,  8'h02,       8'd0);
    add_step("ball_pos",   RESBL,  8'h00,       8'd1);
    add_step("ball_w2",    CTRLPF, 8'h10,       8'd1);
    add_step("ball_w4",    CTRLPF, 8'h21,       8'd1);
    add_step("ball_move",  RESBL,  8'h00,       8'd1);
    add_step("ball_w8",    CTRLPF, 8'h32,       8'd2);
    add_step("vblank_on",  VBLANK, 8'h02,       8'd1);
    add_step("vblank_off", VBLANK, 8'h00,       8'd1);
  endtask

  task automatic write_reg(input addr_t addr, input data_t data);
    int   tries;
    logic taken;
    tries = 0;
    taken = 1'b0;
    @(negedge clk);
    stb = 1'b1;
    we  = 1'b1;
    adr = addr;
    dat = data;
    while (!taken && tries < BUS_TIMEOUT) begin
      @(posedge clk);
      taken = cpu_enable;        // Lands on an edge with a CPU slot
      tries++;
    end
    @(negedge clk);
    stb = 1'b0;
    we  = 1'b0;
    if (!taken) note_timeout("bus write slot");
  endtask

  task automatic read_reg(input addr_t addr, output data_t data);
    @(negedge clk);
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    @(negedge clk);
    stb  = 1'b0;
    data = dat_rd;               // One cycle latency
  endtask

  task automatic wait_xpos(input int target);
    int tries;
    tries = 0;
    do begin
      @(negedge clk);
      tries++;
    end while (vid_xpos != target && tries < LINE_TIMEOUT);
    if (vid_xpos != target) note_timeout("beam position");
  endtask

  task automatic run_lines(input int n);
    repeat (n) wait_xpos(LINE_CLOCKS - 1);
  endtask

  initial begin
    seed     = 32'h5e3c3834;
    reset    = 1'b1;
    enable   = 1'b1;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat      = '0;
    cur_name = "reset";
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("stall", 0, stall_cpu);
    check_value("vid_wr", 0, vid_wr);
    read_reg(CXBLPF, rd_val);
    check_value("cxblpf", 8'h00, rd_val);

    for (int i = 0; i < steps.size(); i++) begin
      cur_name = steps[i].name;
      if (steps[i].addr == RESBL) wait_xpos(10 + $unsigned($random(seed)) % 130);
      write_reg(steps[i].addr, steps[i].data);
      run_lines(steps[i].lines);
    end

    cur_name = "collision";
    write_reg(ENABL, 8'h00);
    write_reg(PF0, 8'hf0);
    write_reg(PF1, 8'hff);
    write_reg(PF2, 8'hff);
    write_reg(CXCLR, 8'h00);
    read_reg(CXBLPF, rd_val);
    check_value("cx_clear", 8'h00, rd_val);
    write_reg(ENABL, 8'h02);
    run_lines(1);
    read_reg(CXBLPF, rd_val);
    check_value("cx_set", 8'h80, rd_val);
    write_reg(ENABL, 8'h00);
    write_reg(CXCLR, 8'h00);
    read_reg(CXBLPF, rd_val);
    check_value("cx_clear", 8'h00, rd_val);

    cur_name = "wsync";
    wait_xpos(20);
    write_reg(WSYNC, 8'h00);
    check_value("stall_on", 1, stall_cpu);
    last_x = vid_xpos;
    waited = 0;
    while (stall_cpu && waited < LINE_TIMEOUT) begin
      last_x = vid_xpos;
      @(negedge clk);
      waited++;
    end
    if (stall_cpu) begin
      note_timeout("stall release");
    end else begin
      check_value("stall_x", VISIBLE_W, last_x);
    end

    cur_name = "vsync";
    write_reg(VSYNC, 8'h02);
    check_value("restart_x", 0, vid_xpos);
    check_value("restart_y", 0, vid_ypos);
    write_reg(VSYNC, 8'h00);
    run_lines(2);

    @(negedge clk);
    $display("Summary: checker %0d checks %0d errors, testbench %0d checks %0d errors",
             chk_checks, chk_errors, tb_checks, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/tia_pkg.sv
rtl/tia_beam_if.sv
rtl/tia_pf_if.sv
rtl/tia_regs.sv
rtl/tia_beam.sv
rtl/tia_render.sv
rtl/tia_top.sv
verif/tia_checker.sv
verif/tia_tb.sv
